// File: verilog.f
+incdir+.
dcache_pkg.sv
dcache_tag_store.sv
dcache_ctrl.sv
dcache.sv
tb_ram.sv
tb_dcache.sv

// File: Makefile
# Verilator simulation of the data cache testbench
# the test target fails when sim.log shows the fail message or lacks the pass message

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run tb_dcache, result checked in sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	rm -f sim.log
	verilator --binary --timing --assert --top-module tb_dcache -f verilog.f -o sim_dcache
	./obj_dir/sim_dcache | tee sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
		echo "TEST FAILED"; exit 1; \
	else \
		echo "TEST PASSED"; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: tb_dcache.sv
// testbench for the data cache, table driven, one request at a time
// read and write counts in the table are totals after each entry
// the halt entry must come last, the cache stays flushed afterwards
module tb_dcache;

	localparam int N_TESTS = 20;

	typedef enum logic [1:0] {OP_LOAD, OP_STORE, OP_HALT, OP_PEEK} op_t;

	typedef struct packed {
		op_t op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [15:0] rd; // memory reads so far
		logic [15:0] wr; // memory writes so far
	} entry_t;

	logic CLK;
	logic nRST;
	logic halt;
	logic flushed;
	dcache_pkg::cpu_req_t req;
	dcache_pkg::cpu_rsp_t rsp;
	dcache_pkg::mem_req_t mreq;
	dcache_pkg::mem_rsp_t mrsp;
	logic [15:0] rd_cnt, wr_cnt;

	entry_t tbl [N_TESTS];
	logic [31:0] shadow [256]; // expected memory image
	int errors;
	int checks;

	dcache DUT (
		.CLK(CLK),
		.nRST(nRST),
		.req(req),
		.halt(halt),
		.rsp(rsp),
		.flushed(flushed),
		.mreq(mreq),
		.mrsp(mrsp)
	);

	tb_ram u_ram (
		.CLK(CLK),
		.nRST(nRST),
		.mreq(mreq),
		.mrsp(mrsp),
		.rd_cnt(rd_cnt),
		.wr_cnt(wr_cnt)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic fill_table();
		// set 1 block, then store and reload in set 2
		tbl[0] = '{OP_LOAD, 32'h0000_0008, 32'h0, 16'd2, 16'd0};
		tbl[1] = '{OP_LOAD, 32'h0000_000c, 32'h0, 16'd2, 16'd0};
		tbl[2] = '{OP_STORE, 32'h0000_0010, 32'h1111_2222, 16'd4, 16'd0};
		tbl[3] = '{OP_LOAD, 32'h0000_0010, 32'h0, 16'd4, 16'd0};
		// three tags in set 3, tag 0 ends up least recently used
		tbl[4] = '{OP_LOAD, 32'h0000_0018, 32'h0, 16'd6, 16'd0};
		tbl[5] = '{OP_LOAD, 32'h0000_0058, 32'h0, 16'd8, 16'd0};
		tbl[6] = '{OP_LOAD, 32'h0000_001c, 32'h0, 16'd8, 16'd0};
		tbl[7] = '{OP_LOAD, 32'h0000_005c, 32'h0, 16'd8, 16'd0};
		tbl[8] = '{OP_LOAD, 32'h0000_0098, 32'h0, 16'd10, 16'd0};
		tbl[9] = '{OP_LOAD, 32'h0000_005c, 32'h0, 16'd10, 16'd0};
		tbl[10] = '{OP_LOAD, 32'h0000_0018, 32'h0, 16'd12, 16'd0};
		// dirty victims in set 4
		tbl[11] = '{OP_STORE, 32'h0000_0020, 32'hdead_beef, 16'd14, 16'd0};
		tbl[12] = '{OP_STORE, 32'h0000_0064, 32'hcafe_f00d, 16'd16, 16'd0};
		tbl[13] = '{OP_LOAD, 32'h0000_00a0, 32'h0, 16'd18, 16'd2};
		tbl[14] = '{OP_PEEK, 32'h0000_0020, 32'h0, 16'd18, 16'd2};
		tbl[15] = '{OP_LOAD, 32'h0000_0020, 32'h0, 16'd20, 16'd4};
		tbl[16] = '{OP_PEEK, 32'h0000_0064, 32'h0, 16'd20, 16'd4};
		tbl[17] = '{OP_STORE, 32'h0000_00a4, 32'h0bad_cafe, 16'd20, 16'd4};
		tbl[18] = '{OP_STORE, 32'h0000_0008, 32'h1234_5678, 16'd20, 16'd4};
		tbl[19] = '{OP_HALT, 32'h0, 32'h0, 16'd20, 16'd10}; // three dirty frames
	endtask

	task automatic run_entry(input entry_t e, input int num);
		int err_before;
		err_before = errors;
		case (e.op)
			OP_LOAD: req <= '{ren: 1'b1, wen: 1'b0, addr: e.addr, store: 32'h0};
			OP_STORE: req <= '{ren: 1'b0, wen: 1'b1, addr: e.addr, store: e.data};
			OP_HALT: begin
				req <= '0;
				halt <= 1'b1;
			end
			default: req <= '0; // peek only looks at tb_ram
		endcase
		@(negedge CLK);
		if (e.op == OP_HALT) begin
			while (!flushed) @(negedge CLK);
		end
		else if (e.op != OP_PEEK) begin
			while (!rsp.hit) @(negedge CLK);
		end
		if (e.op == OP_STORE) begin
			shadow[e.addr[9:2]] = e.data;
		end
		if (e.op == OP_LOAD) begin
			checks++;
			if (rsp.load !== shadow[e.addr[9:2]]) begin
				$display("ERR rsp.load got %h exp %h", rsp.load, shadow[e.addr[9:2]]);
				errors++;
			end
		end
		checks++;
		if (rd_cnt !== e.rd) begin
			$display("ERR rd_cnt got %h exp %h", rd_cnt, e.rd);
			errors++;
		end
		checks++;
		if (wr_cnt !== e.wr) begin
			$display("ERR wr_cnt got %h exp %h", wr_cnt, e.wr);
			errors++;
		end
		if (e.op == OP_PEEK) begin
			checks++;
			if (u_ram.mem[e.addr[9:2]] !== shadow[e.addr[9:2]]) begin
				$display("ERR mem[%h] got %h exp %h", e.addr,
					u_ram.mem[e.addr[9:2]], shadow[e.addr[9:2]]);
				errors++;
			end
		end
		if (e.op == OP_HALT) begin
			for (int k = 0; k < 256; k++) begin // whole image after the flush
				checks++;
				if (u_ram.mem[k] !== shadow[k]) begin
					$display("ERR mem[%h] got %h exp %h", k << 2, u_ram.mem[k], shadow[k]);
					errors++;
				end
			end
		end
		$display("test %0d %s addr %h %s", num, e.op.name(), e.addr,
			(errors == err_before) ? "pass" : "fail");
		@(posedge CLK);
	endtask

	initial begin
		void'($urandom(32'hef3b_0cbd));
		req = '0;
		halt = 1'b0;
		nRST = 1'b0;
		errors = 0;
		checks = 0;
		fill_table();
		for (int k = 0; k < 256; k++) begin
			shadow[k] = (k << 2) ^ 32'h5a5a_0000;
		end
		repeat (3) @(posedge CLK);
		nRST <= 1'b1;
		@(posedge CLK);
		for (int i = 0; i < N_TESTS; i++) begin
			run_entry(tbl[i], i);
		end
		$display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end
		else begin
			$display("Errors found");
		end
		$finish;
	end

	// table length plus one slot for reset
	initial begin
		#((N_TESTS + 1) * 200);
		$display("timeout: the cache stopped answering");
		$display("Errors found");
		$finish;
	end

endmodule

// File: tb_ram.sv
// memory model for the cache testbench, 256 words indexed by addr[9:2]
// higher address bits alias; each word waits 0 to 2 cycles at random
module tb_ram (
	input logic CLK,
	input logic nRST,
	input dcache_pkg::mem_req_t mreq,
	output dcache_pkg::mem_rsp_t mrsp,
	output logic [15:0] rd_cnt,
	output logic [15:0] wr_cnt
);

	logic [31:0] mem [256];
	logic [1:0] wait_left; // stall cycles left for the current word
	logic active;
	logic done; // word transfer completes this cycle

	assign active = mreq.ren | mreq.wen;
	assign done = active && (wait_left == 2'd0);
	assign mrsp.dwait = active && !done;
	assign mrsp.load = mem[mreq.addr[9:2]];

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = (i << 2) ^ 32'h5a5a_0000; // word marked with its own address
		end
	end

	always @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wait_left <= 2'd0;
			rd_cnt <= '0;
			wr_cnt <= '0;
		end
		else if (done) begin
			wait_left <= 2'($urandom % 3); // stall before the next word
			if (mreq.wen) begin
				wr_cnt <= wr_cnt + 16'd1;
			end
			else begin
				rd_cnt <= rd_cnt + 16'd1;
			end
		end
		else if (active) begin
			wait_left <= wait_left - 2'd1;
		end
	end

	always @(posedge CLK) begin
		if (done && mreq.wen) begin
			mem[mreq.addr[9:2]] <= mreq.store;
		end
	end

endmodule

// File: dcache.sv
// 2-way write-back data cache, 8 sets of two-word blocks
// processor holds each request until hit; memory stalls with dwait
// after halt the cache flushes and stays flushed until reset

module dcache (
	input logic CLK,
	input logic nRST,
	input dcache_pkg::cpu_req_t req,
	input logic halt,
	output dcache_pkg::cpu_rsp_t rsp,
	output logic flushed,
	output dcache_pkg::mem_req_t mreq,
	input dcache_pkg::mem_rsp_t mrsp
);

	dcache_pkg::frame_t way0, way1, flush_frame;
	logic hit, hit_way, lru;
	dcache_pkg::line_upd_t upd;
	logic lru_upd, lru_way;
	dcache_pkg::idx_t flush_idx;
	logic flush_way;

	dcache_tag_store u_store (
		.CLK(CLK),
		.nRST(nRST),
		.addr(req.addr), // lookup always at the request address
		.flush_idx(flush_idx),
		.flush_way(flush_way),
		.upd(upd),
		.lru_upd(lru_upd),
		.lru_way(lru_way),
		.way0(way0),
		.way1(way1),
		.hit(hit),
		.hit_way(hit_way),
		.lru(lru),
		.flush_frame(flush_frame)
	);

	dcache_ctrl u_ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.req(req),
		.halt(halt),
		.way0(way0),
		.way1(way1),
		.hit(hit),
		.hit_way(hit_way),
		.lru(lru),
		.flush_frame(flush_frame),
		.mrsp(mrsp),
		.rsp(rsp),
		.flushed(flushed),
		.mreq(mreq),
		.upd(upd),
		.lru_upd(lru_upd),
		.lru_way(lru_way),
		.flush_idx(flush_idx),
		.flush_way(flush_way)
	);

endmodule

// File: dcache_ctrl.sv
// miss handling and halt flush for the data cache
// one request at a time, held by the processor until hit
// victim is written back as two words, then the block filled word 0 first
`include "dcache_defines.svh"

module dcache_ctrl (
	input logic CLK,
	input logic nRST,
	input dcache_pkg::cpu_req_t req,
	input logic halt,
	input dcache_pkg::frame_t way0,
	input dcache_pkg::frame_t way1,
	input logic hit,
	input logic hit_way,
	input logic lru,
	input dcache_pkg::frame_t flush_frame,
	input dcache_pkg::mem_rsp_t mrsp,
	output dcache_pkg::cpu_rsp_t rsp,
	output logic flushed,
	output dcache_pkg::mem_req_t mreq,
	output dcache_pkg::line_upd_t upd,
	output logic lru_upd,
	output logic lru_way,
	output dcache_pkg::idx_t flush_idx,
	output logic flush_way
);

	dcache_pkg::ctrl_state_t state, nxt_state;
	logic [4:0] flush_cnt, nxt_flush_cnt; // bit 3 picks way, bit 4 means done
	dcache_pkg::tag_t tag;
	dcache_pkg::idx_t idx;
	logic offset;
	logic pending;
	dcache_pkg::frame_t hit_frame, victim;

	assign tag = req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
	assign idx = req.addr[`DC_ADDR_W-`DC_TAG_W-1 -: `DC_IDX_W];
	assign offset = req.addr[2];
	assign pending = req.ren | req.wen;

	assign hit_frame = hit_way ? way1 : way0;
	assign victim = lru ? way1 : way0;

	assign flush_idx = flush_cnt[2:0];
	assign flush_way = flush_cnt[3];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= dcache_pkg::IDLE;
			flush_cnt <= '0;
		end
		else begin
			state <= nxt_state;
			flush_cnt <= nxt_flush_cnt;
		end
	end

	always_comb begin
		nxt_state = state;
		nxt_flush_cnt = flush_cnt;
		rsp = '0;
		flushed = 1'b0;
		mreq = '0;
		upd = '0;
		lru_upd = 1'b0;
		lru_way = hit_way;

		case (state)
			dcache_pkg::IDLE: begin
				if (pending && hit) begin
					rsp.hit = 1'b1;
					rsp.load = hit_frame.data[offset];
					lru_upd = 1'b1;
					if (req.wen) begin // merge store word, mark dirty
						upd.en = 1'b1;
						upd.way = hit_way;
						upd.idx = idx;
						upd.frame = hit_frame;
						upd.frame.dirty = 1'b1;
						upd.frame.data[offset] = req.store;
					end
				end
				else if (pending) begin
					nxt_state = victim.dirty ? dcache_pkg::WB1 : dcache_pkg::LD1;
				end
				else if (halt) begin
					nxt_flush_cnt = '0;
					nxt_state = dcache_pkg::DIRTY;
				end
			end

			dcache_pkg::WB1, dcache_pkg::WB2: begin
				mreq.wen = 1'b1;
				mreq.addr = {victim.tag, idx, state == dcache_pkg::WB2, 2'b00};
				mreq.store = victim.data[state == dcache_pkg::WB2];
				if (!mrsp.dwait) begin
					nxt_state = (state == dcache_pkg::WB1) ? dcache_pkg::WB2 : dcache_pkg::LD1;
				end
			end

			dcache_pkg::LD1: begin
				mreq.ren = 1'b1;
				mreq.addr = {tag, idx, 3'b000};
				// park word 0 in the victim, invalid until the second word
				upd.en = !mrsp.dwait;
				upd.way = lru;
				upd.idx = idx;
				upd.frame = '{valid: 1'b0, dirty: 1'b0, tag: tag,
					data: {victim.data[1], mrsp.load}};
				if (!mrsp.dwait) begin
					nxt_state = dcache_pkg::LD2;
				end
			end

			dcache_pkg::LD2: begin
				mreq.ren = 1'b1;
				mreq.addr = {tag, idx, 3'b100};
				upd.en = !mrsp.dwait;
				upd.way = lru;
				upd.idx = idx;
				upd.frame = '{valid: 1'b1, dirty: 1'b0, tag: tag,
					data: {mrsp.load, victim.data[0]}};
				if (!mrsp.dwait) begin
					nxt_state = dcache_pkg::IDLE; // retry hits there
				end
			end

			dcache_pkg::DIRTY: begin
				if (flush_cnt[4]) begin
					nxt_state = dcache_pkg::HALT;
				end
				else if (flush_frame.dirty) begin
					nxt_state = dcache_pkg::FLUSH1;
				end
				else begin
					nxt_flush_cnt = flush_cnt + 5'd1; // clean frame, skip
				end
			end

			dcache_pkg::FLUSH1: begin
				mreq.wen = 1'b1;
				mreq.addr = {flush_frame.tag, flush_idx, 3'b000};
				mreq.store = flush_frame.data[0];
				if (!mrsp.dwait) begin
					nxt_state = dcache_pkg::FLUSH2;
				end
			end

			dcache_pkg::FLUSH2: begin
				mreq.wen = 1'b1;
				mreq.addr = {flush_frame.tag, flush_idx, 3'b100};
				mreq.store = flush_frame.data[1];
				if (!mrsp.dwait) begin
					upd.en = 1'b1;
					upd.way = flush_way;
					upd.idx = flush_idx;
					upd.frame = flush_frame;
					upd.frame.dirty = 1'b0;
					nxt_flush_cnt = flush_cnt + 5'd1;
					nxt_state = dcache_pkg::DIRTY;
				end
			end

			dcache_pkg::HALT: begin
				flushed = 1'b1; // held until reset
			end

			default: begin
				nxt_state = dcache_pkg::IDLE;
			end
		endcase
	end

	// victim keeps its dirty block until both words are written back
	a_wb_victim_dirty: assert property (@(posedge CLK) disable iff (!nRST)
		(state == dcache_pkg::WB1 || state == dcache_pkg::WB2)
		|-> victim.valid && victim.dirty);

	// a flush write only ever targets a dirty frame
	a_flush_frame_dirty: assert property (@(posedge CLK) disable iff (!nRST)
		(state == dcache_pkg::FLUSH1 || state == dcache_pkg::FLUSH2)
		|-> flush_frame.valid && flush_frame.dirty);

endmodule

// File: dcache_tag_store.sv
// frame arrays of both ways plus one LRU bit per set
// lookup is combinational, writes land on the next edge
// lru bit names the way to evict next
`include "dcache_defines.svh"

module dcache_tag_store (
	input logic CLK,
	input logic nRST,
	input logic [`DC_ADDR_W-1:0] addr,
	input dcache_pkg::idx_t flush_idx,
	input logic flush_way,
	input dcache_pkg::line_upd_t upd,
	input logic lru_upd,
	input logic lru_way,
	output dcache_pkg::frame_t way0,
	output dcache_pkg::frame_t way1,
	output logic hit,
	output logic hit_way,
	output logic lru,
	output dcache_pkg::frame_t flush_frame
);

	dcache_pkg::tag_t tag;
	dcache_pkg::idx_t idx;
	logic hit0, hit1;

	// valid and dirty per way, indexed [way][set]
	logic [1:0][`DC_SETS-1:0] valid_bits;
	logic [1:0][`DC_SETS-1:0] dirty_bits;
	logic [`DC_SETS-1:0] lru_bits;
	dcache_pkg::tag_t tag_mem [2][`DC_SETS];
	dcache_pkg::word_t [`DC_WORDS-1:0] data_mem [2][`DC_SETS];

	assign tag = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
	assign idx = addr[`DC_ADDR_W-`DC_TAG_W-1 -: `DC_IDX_W];

	function automatic dcache_pkg::frame_t read_frame(input logic way,
			input dcache_pkg::idx_t i);
		dcache_pkg::frame_t f;
		f.valid = valid_bits[way][i];
		f.dirty = dirty_bits[way][i];
		f.tag = tag_mem[way][i];
		f.data = data_mem[way][i];
		return f;
	endfunction

	always_comb begin
		way0 = read_frame(1'b0, idx);
		way1 = read_frame(1'b1, idx);
		flush_frame = read_frame(flush_way, flush_idx); // flush scan pointer
	end

	assign hit0 = way0.valid && (way0.tag == tag);
	assign hit1 = way1.valid && (way1.tag == tag);
	assign hit = hit0 | hit1;
	assign hit_way = hit1;
	assign lru = lru_bits[idx];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_bits <= '0;
			dirty_bits <= '0;
			lru_bits <= '0;
		end
		else begin
			if (upd.en) begin
				valid_bits[upd.way][upd.idx] <= upd.frame.valid;
				dirty_bits[upd.way][upd.idx] <= upd.frame.dirty;
			end
			if (lru_upd) begin
				lru_bits[idx] <= ~lru_way; // other way becomes victim
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (upd.en) begin
			tag_mem[upd.way][upd.idx] <= upd.frame.tag;
			data_mem[upd.way][upd.idx] <= upd.frame.data;
		end
	end

	// a fill must never leave a second valid copy of a tag in the set
	a_single_hit: assert property (@(posedge CLK) disable iff (!nRST)
		!(hit0 && hit1));

endmodule

// File: dcache_pkg.sv
// shared types for the data cache
// widths come from the defines header
`include "dcache_defines.svh"

package dcache_pkg;

	typedef logic [`DC_WORD_W-1:0] word_t;
	typedef logic [`DC_TAG_W-1:0] tag_t;
	typedef logic [`DC_IDX_W-1:0] idx_t;

	// one block frame, 92 bits
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
		word_t [`DC_WORDS-1:0] data;
	} frame_t;

	typedef struct packed {
		logic ren;
		logic wen;
		logic [`DC_ADDR_W-1:0] addr;
		word_t store;
	} cpu_req_t;

	typedef struct packed {
		logic hit; // strobe, request retires this cycle
		word_t load;
	} cpu_rsp_t;

	typedef struct packed {
		logic ren;
		logic wen;
		logic [`DC_ADDR_W-1:0] addr;
		word_t store;
	} mem_req_t;

	typedef struct packed {
		logic dwait; // level, transfer stalls while high
		word_t load;
	} mem_rsp_t;

	// frame write from the controller into the store
	typedef struct packed {
		logic en;
		logic way;
		idx_t idx;
		frame_t frame;
	} line_upd_t;

	typedef enum logic [3:0] {
		IDLE, WB1, WB2, LD1, LD2, DIRTY, FLUSH1, FLUSH2, HALT
	} ctrl_state_t;

endpackage

// File: dcache_defines.svh
// cache geometry for the 2-way write-back data cache
// byte address, word aligned; bits 1:0 are always zero
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

`define DC_ADDR_W 32 // byte address
`define DC_WORD_W 32

// tag is addr[31:6], index addr[5:3], word select addr[2]
`define DC_TAG_W 26
`define DC_IDX_W 3

`define DC_SETS 8
`define DC_WORDS 2 // words per block

`endif
